/* flist.f */
design/axil_pkg.sv
design/soc_map_pkg.sv
design/axil_decoder.sv
design/boot_ram.sv
design/gfx_regs.sv
design/gfx_timing.sv
design/soc_fabric_top.sv
sim/soc_fabric_sva.sv
sim/tb_soc_fabric.sv

/* Makefile */
# Verilator build and run of the SoC fabric testbench

VERILATOR ?= verilator
TOP       ?= tb_soc_fabric
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FLIST OBJ_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Verification failed" $(LOG); then echo "FAIL, see $(LOG)"; exit 1; fi
	@grep -q "Verification passed" $(LOG) || { echo "No result in $(LOG)"; exit 1; }
	@echo "PASS"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* sim/tb_soc_fabric.sv */
`timescale 1ns/1ns

module tb_soc_fabric;
	import axil_pkg::*;
	import soc_map_pkg::*;

	localparam int BOOT_N = 16;
	localparam int STRB_N = 32;
	localparam int BP_N = 40;
	localparam int BP_MAX = 8;
	localparam int ORDER_N = 4;
	localparam int RUN_CYC = 300;
	localparam int TXN_N = 2 + 2 * BOOT_N + STRB_N + 24 + 12 + 8 + 3 * BP_N + 5 * ORDER_N;
	localparam int WD_CYC = 2 * (TXN_N * (BP_MAX + 12) + 2 * RUN_CYC + 8);
	// Former SDRAM and SD-card ranges, plus just past each window
	localparam logic [31:0] UNMAPPED [4] = '{32'h0400_0000, 32'h0300_0010,
		32'h0201_1000, 32'h0200_0100};

	logic hdmi_pixClk;
	logic arst_n;
	axil_req_t bus_req;
	axil_rsp_t bus_rsp;
	logic vsync;

	int seed = 32'hb02d;
	int unsigned bp_max = 0;
	int vsync_total = 0;
	int n_checks = 0;
	int n_errors = 0;
	bit main_done = 1'b0;
	bit wd_fired = 1'b0;

	logic [DATA_W-1:0] shadow_mem [BOOT_WORDS];
	logic sh_enable = 1'b0;
	logic [TIMING_W-1:0] sh_h_total = '0;
	logic [TIMING_W-1:0] sh_v_total = '0;
	logic [DATA_W-1:0] sh_frames = '0;
	logic [BOOT_ADDR_BITS-3:0] idx_list [BOOT_N];

	string name_q [$];
	logic [33:0] exp_q [$];
	logic [33:0] act_q [$];

	soc_fabric_top soc_fabric_top_inst (
		.hdmi_pixClk (hdmi_pixClk),
		.arst_n      (arst_n),
		.bus_req     (bus_req),
		.bus_rsp     (bus_rsp),
		.vsync       (vsync)
	);

	initial begin
		hdmi_pixClk = 1'b0;
		forever #2 hdmi_pixClk = ~hdmi_pixClk;
	end

	function automatic logic [31:0] rnd();
		return $random(seed);
	endfunction

	function automatic int unsigned pick_delay();
		return $unsigned($random(seed)) % (bp_max + 1);
	endfunction

	function automatic logic [31:0] boot_addr(input logic [BOOT_ADDR_BITS-3:0] idx);
		return BOOT_BASE | {20'd0, idx, 2'b00};
	endfunction

	// Expected {resp, data} of a read, from the address map and shadow state
	function automatic logic [33:0] ref_read(input logic [31:0] addr);
		if (addr[31:12] == BOOT_BASE[31:12])
			return {RESP_OKAY, shadow_mem[addr[11:2]]};
		if (addr[31:8] == GFX_BASE[31:8]) begin
			case (addr[7:2])
				6'd0: return {RESP_OKAY, 31'd0, sh_enable};
				6'd1: return {RESP_OKAY, 20'd0, sh_h_total};
				6'd2: return {RESP_OKAY, 20'd0, sh_v_total};
				6'd3: return {RESP_OKAY, sh_frames};
				default: return {RESP_OKAY, 32'd0};
			endcase
		end
		return {RESP_DECERR, 32'd0};
	endfunction

	task automatic check(input string name, input logic [33:0] exp, input logic [33:0] act);
		n_checks++;
		if (exp !== act) begin
			n_errors++;
			$display("mismatch %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic post_compare(input string name, input logic [33:0] exp,
		input logic [33:0] act);
		name_q.push_back(name);
		exp_q.push_back(exp);
		act_q.push_back(act);
	endtask

	// Compare off the falling edge, away from stimulus
	always @(negedge hdmi_pixClk) begin
		while (act_q.size() > 0)
			check(name_q.pop_front(), exp_q.pop_front(), act_q.pop_front());
	end

	always @(posedge hdmi_pixClk) begin
		if (vsync)
			vsync_total <= vsync_total + 1;
	end

	task automatic axil_write(input logic [31:0] addr, input logic [31:0] data,
		input logic [3:0] strb, output axil_resp_e resp);
		axil_resp_e first;
		@(posedge hdmi_pixClk);
		bus_req.awvalid <= 1'b1;
		bus_req.awaddr <= addr;
		bus_req.wvalid <= 1'b1;
		bus_req.wdata <= data;
		bus_req.wstrb <= strb;
		do @(posedge hdmi_pixClk); while (!bus_rsp.awready);
		post_compare("wready with awready", 34'd1, {33'd0, bus_rsp.wready});
		bus_req.awvalid <= 1'b0;
		bus_req.wvalid <= 1'b0;
		do @(posedge hdmi_pixClk); while (!bus_rsp.bvalid);
		first = bus_rsp.bresp;
		repeat (pick_delay()) @(posedge hdmi_pixClk); // Back-pressure
		bus_req.bready <= 1'b1;
		@(posedge hdmi_pixClk);
		bus_req.bready <= 1'b0;
		resp = bus_rsp.bresp;
		post_compare("bresp held", {32'd0, first}, {32'd0, resp});
	endtask

	task automatic axil_read(input logic [31:0] addr, output logic [31:0] data,
		output axil_resp_e resp);
		logic [33:0] first;
		@(posedge hdmi_pixClk);
		bus_req.arvalid <= 1'b1;
		bus_req.araddr <= addr;
		do @(posedge hdmi_pixClk); while (!bus_rsp.arready);
		bus_req.arvalid <= 1'b0;
		do @(posedge hdmi_pixClk); while (!bus_rsp.rvalid);
		first = {bus_rsp.rresp, bus_rsp.rdata};
		repeat (pick_delay()) @(posedge hdmi_pixClk);
		bus_req.rready <= 1'b1;
		@(posedge hdmi_pixClk);
		bus_req.rready <= 1'b0;
		data = bus_rsp.rdata;
		resp = bus_rsp.rresp;
		post_compare("read held", first, {resp, data});
	endtask

	task automatic write_tracked(input string name, input logic [31:0] addr,
		input logic [31:0] data, input logic [3:0] strb);
		logic [33:0] expd;
		logic [31:0] mask;
		axil_resp_e resp;
		expd = ref_read(addr); // Write answers like a read of the same address
		axil_write(addr, data, strb, resp);
		post_compare(name, {32'd0, expd[33:32]}, {32'd0, resp});
		mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
		if (addr[31:12] == BOOT_BASE[31:12]) begin
			shadow_mem[addr[11:2]] = (shadow_mem[addr[11:2]] & ~mask) | (data & mask);
		end else if (addr[31:8] == GFX_BASE[31:8]) begin
			case (addr[7:2])
				6'd0: sh_enable = data[0];
				6'd1: sh_h_total = data[TIMING_W-1:0];
				6'd2: sh_v_total = data[TIMING_W-1:0];
				default: ;
			endcase
		end
	endtask

	task automatic read_checked(input string name, input logic [31:0] addr);
		logic [31:0] data;
		axil_resp_e resp;
		axil_read(addr, data, resp);
		post_compare(name, ref_read(addr), {resp, data});
	endtask

	initial begin
		logic [31:0] a;
		int base;
		logic [31:0] d;
		axil_resp_e r;
		logic [33:0] e;
		bus_req <= '0;
		arst_n <= 1'b0;
		repeat (8) @(posedge hdmi_pixClk);
		arst_n <= 1'b1;
		@(posedge hdmi_pixClk);
		post_compare("reset outputs", 34'd0, {28'd0, bus_rsp.awready, bus_rsp.wready,
			bus_rsp.arready, bus_rsp.bvalid, bus_rsp.rvalid, vsync});
		read_checked("reset ctrl", GFX_BASE);
		read_checked("reset frame count", GFX_BASE + 32'hc);

		// Full words first so no unwritten word is read back
		foreach (idx_list[i]) begin
			idx_list[i] = 10'(rnd());
			write_tracked("boot fill", boot_addr(idx_list[i]), rnd(), 4'hf);
		end
		repeat (STRB_N)
			write_tracked("boot strobe write", boot_addr(idx_list[4'(rnd())]), rnd(), 4'(rnd()));
		foreach (idx_list[i])
			read_checked("boot readback", boot_addr(idx_list[i]));

		for (int i = 0; i < 4; i++) begin
			write_tracked("decerr write", UNMAPPED[i], rnd(), 4'hf);
			read_checked("decerr read", UNMAPPED[i]);
		end
		foreach (idx_list[i])
			read_checked("boot after decerr", boot_addr(idx_list[i]));

		write_tracked("h_total write", GFX_BASE + 32'h4, rnd(), 4'hf);
		write_tracked("v_total write", GFX_BASE + 32'h8, rnd(), 4'hf);
		read_checked("h_total readback", GFX_BASE + 32'h4);
		read_checked("v_total readback", GFX_BASE + 32'h8);
		write_tracked("frame count write", GFX_BASE + 32'hc, rnd(), 4'hf);
		write_tracked("hole write", GFX_BASE + 32'h10, rnd(), 4'hf);
		write_tracked("hole write", GFX_BASE + 32'hfc, rnd(), 4'hf);
		read_checked("frame count after write", GFX_BASE + 32'hc);
		read_checked("hole readback", GFX_BASE + 32'h10);
		read_checked("h_total unchanged", GFX_BASE + 32'h4);
		read_checked("v_total unchanged", GFX_BASE + 32'h8);

		// 4 pixels by 3 lines per frame
		write_tracked("h_total small", GFX_BASE + 32'h4, 32'd3, 4'hf);
		write_tracked("v_total small", GFX_BASE + 32'h8, 32'd2, 4'hf);
		repeat (2) begin
			base = vsync_total;
			write_tracked("enable", GFX_BASE, 32'd1, 4'hf);
			read_checked("ctrl enabled", GFX_BASE);
			repeat (RUN_CYC) @(posedge hdmi_pixClk);
			write_tracked("disable", GFX_BASE, 32'd0, 4'hf);
			sh_frames = vsync_total - base;
			post_compare("vsync pulses seen", 34'd1, {33'd0, sh_frames != 0});
			read_checked("frame count", GFX_BASE + 32'hc);
		end

		bp_max = BP_MAX;
		repeat (BP_N) begin
			a = boot_addr(idx_list[4'(rnd())]);
			write_tracked("bp boot write", a, rnd(), 4'hf & 4'(rnd()));
			read_checked("bp boot read", a);
			read_checked("bp reg read", GFX_BASE | {26'd0, 4'(rnd()), 2'b00});
		end

		// Write and read presented together, then a write held off by a pending read
		repeat (ORDER_N) begin
			a = boot_addr(idx_list[4'(rnd())]);
			fork
				write_tracked("race write", a, rnd(), 4'hf);
				axil_read(a, d, r);
			join
			post_compare("read after racing write", ref_read(a), {r, d});
			a = boot_addr(idx_list[4'(rnd())]);
			e = ref_read(a);
			fork
				axil_read(a, d, r);
				begin
					@(posedge hdmi_pixClk);
					write_tracked("late write", a, rnd(), 4'hf);
				end
			join
			post_compare("read before late write", e, {r, d});
			read_checked("late write landed", a);
		end

		repeat (2) @(posedge hdmi_pixClk);
		main_done = 1'b1;
		$display("Checks: %0d, errors: %0d", n_checks, n_errors);
		if (n_errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

	initial begin
		repeat (WD_CYC) @(posedge hdmi_pixClk);
		wd_fired = 1'b1;
		$display("Timeout: tests did not finish within %0d cycles", WD_CYC);
		$display("Verification failed");
		$finish;
	end

	// Run stopped early, e.g. by a failing assertion
	final begin
		if (!main_done && !wd_fired)
			$display("Verification failed");
	end

endmodule

/* sim/soc_fabric_sva.sv */
`timescale 1ns/1ns

module soc_fabric_sva (
	input logic                hdmi_pixClk,
	input logic                arst_n,
	input axil_pkg::axil_req_t bus_req,
	input axil_pkg::axil_rsp_t bus_rsp,
	input logic                vsync
);

	// Master side held until accepted
	aw_held: assert property (@(posedge hdmi_pixClk) disable iff (!arst_n)
		bus_req.awvalid && bus_req.wvalid && !bus_rsp.awready
		|=> bus_req.awvalid && bus_req.wvalid && $stable(bus_req.awaddr))
		else $error("write request dropped or changed before awready");

	ar_held: assert property (@(posedge hdmi_pixClk) disable iff (!arst_n)
		bus_req.arvalid && !bus_rsp.arready |=> bus_req.arvalid && $stable(bus_req.araddr))
		else $error("read request dropped or changed before arready");

	b_held: assert property (@(posedge hdmi_pixClk) disable iff (!arst_n)
		bus_rsp.bvalid && !bus_req.bready |=> bus_rsp.bvalid && $stable(bus_rsp.bresp))
		else $error("write response dropped or changed before bready");

	r_held: assert property (@(posedge hdmi_pixClk) disable iff (!arst_n)
		bus_rsp.rvalid && !bus_req.rready
		|=> bus_rsp.rvalid && $stable(bus_rsp.rdata) && $stable(bus_rsp.rresp))
		else $error("read response dropped or changed before rready");

	vsync_single: assert property (@(posedge hdmi_pixClk) disable iff (!arst_n)
		vsync |=> !vsync)
		else $error("vsync high for more than one cycle");

	reset_quiet: assert property (@(posedge hdmi_pixClk)
		!arst_n |-> !(bus_rsp.awready || bus_rsp.wready || bus_rsp.arready ||
			bus_rsp.bvalid || bus_rsp.rvalid || vsync))
		else $error("ready, valid or vsync high during reset");

endmodule

bind soc_fabric_top soc_fabric_sva soc_fabric_sva_inst (
	.hdmi_pixClk (hdmi_pixClk),
	.arst_n      (arst_n),
	.bus_req     (bus_req),
	.bus_rsp     (bus_rsp),
	.vsync       (vsync)
);

/* design/soc_fabric_top.sv */
`timescale 1ns/1ns

module soc_fabric_top (
	input  logic                hdmi_pixClk,
	input  logic                arst_n,
	input  axil_pkg::axil_req_t bus_req,
	output axil_pkg::axil_rsp_t bus_rsp,
	output logic                vsync
);
	import axil_pkg::*;
	import soc_map_pkg::*;

	axil_req_t boot_req;
	axil_rsp_t boot_rsp;
	axil_req_t gfx_req;
	axil_rsp_t gfx_rsp;
	gfx_ctrl_t gfx_ctrl;
	logic [DATA_W-1:0] frame_cnt;

	axil_decoder axil_decoder_inst (
		.hdmi_pixClk (hdmi_pixClk),
		.arst_n      (arst_n),
		.host_req    (bus_req),
		.host_rsp    (bus_rsp),
		.boot_req    (boot_req),
		.boot_rsp    (boot_rsp),
		.gfx_req     (gfx_req),
		.gfx_rsp     (gfx_rsp)
	);

	boot_ram boot_ram_inst (
		.hdmi_pixClk (hdmi_pixClk),
		.arst_n      (arst_n),
		.req         (boot_req),
		.rsp         (boot_rsp)
	);

	gfx_regs gfx_regs_inst (
		.hdmi_pixClk (hdmi_pixClk),
		.arst_n      (arst_n),
		.req         (gfx_req),
		.rsp         (gfx_rsp),
		.ctrl        (gfx_ctrl),
		.frame_cnt   (frame_cnt)
	);

	gfx_timing gfx_timing_inst (
		.hdmi_pixClk (hdmi_pixClk),
		.arst_n      (arst_n),
		.ctrl        (gfx_ctrl),
		.vsync       (vsync),
		.frame_cnt   (frame_cnt)
	);

endmodule

/* design/gfx_timing.sv */
`timescale 1ns/1ns

module gfx_timing (
	input  logic                        hdmi_pixClk,
	input  logic                        arst_n,
	input  soc_map_pkg::gfx_ctrl_t      ctrl,
	output logic                        vsync,
	output logic [axil_pkg::DATA_W-1:0] frame_cnt
);
	import soc_map_pkg::*;

	logic [TIMING_W-1:0] pix_cnt;
	logic [TIMING_W-1:0] line_cnt;
	logic enable_q;

	always_ff @(posedge hdmi_pixClk or negedge arst_n) begin
		if (!arst_n) begin
			pix_cnt <= '0;
			line_cnt <= '0;
			enable_q <= 1'b0;
			vsync <= 1'b0;
			frame_cnt <= '0;
		end else begin
			enable_q <= ctrl.enable;
			vsync <= 1'b0;
			if (ctrl.enable && !enable_q) begin
				// Restart on enable rise
				pix_cnt <= '0;
				line_cnt <= '0;
				frame_cnt <= '0;
			end else if (ctrl.enable) begin
				if (pix_cnt >= ctrl.h_total) begin
					pix_cnt <= '0;
					if (line_cnt >= ctrl.v_total) begin
						line_cnt <= '0;
						vsync <= 1'b1; // Frame wrap
						frame_cnt <= frame_cnt + 1'b1;
					end else begin
						line_cnt <= line_cnt + 1'b1;
					end
				end else begin
					pix_cnt <= pix_cnt + 1'b1;
				end
			end
		end
	end

endmodule

/* design/gfx_regs.sv */
`timescale 1ns/1ns

module gfx_regs (
	input  logic                          hdmi_pixClk,
	input  logic                          arst_n,
	input  axil_pkg::axil_req_t           req,
	output axil_pkg::axil_rsp_t           rsp,
	output soc_map_pkg::gfx_ctrl_t        ctrl,
	input  logic [axil_pkg::DATA_W-1:0]   frame_cnt
);
	import axil_pkg::*;
	import soc_map_pkg::*;

	logic [DATA_W-1:0] rdata_q;
	logic bvalid_q;
	logic rvalid_q;

	logic busy;
	logic wr_fire;
	logic rd_fire;
	gfx_reg_e wr_reg;
	gfx_reg_e rd_reg;

	assign busy = bvalid_q || rvalid_q;
	assign wr_fire = req.awvalid && req.wvalid && !busy;
	assign rd_fire = req.arvalid && !busy && !(req.awvalid && req.wvalid);

	assign wr_reg = gfx_reg_e'(req.awaddr[GFX_ADDR_BITS-1:2]);
	assign rd_reg = gfx_reg_e'(req.araddr[GFX_ADDR_BITS-1:2]);

	always_comb begin
		rsp.awready = wr_fire;
		rsp.wready = wr_fire;
		rsp.bvalid = bvalid_q;
		rsp.bresp = RESP_OKAY; // Also for ignored writes
		rsp.arready = rd_fire;
		rsp.rvalid = rvalid_q;
		rsp.rdata = rdata_q;
		rsp.rresp = RESP_OKAY;
	end

	always_ff @(posedge hdmi_pixClk or negedge arst_n) begin
		if (!arst_n) begin
			bvalid_q <= 1'b0;
			rvalid_q <= 1'b0;
			ctrl <= '0;
		end else begin
			if (wr_fire) begin
				bvalid_q <= 1'b1;
				// Whole-word writes, fields cut to their width
				case (wr_reg)
					REG_CTRL:    ctrl.enable <= req.wdata[0];
					REG_H_TOTAL: ctrl.h_total <= req.wdata[TIMING_W-1:0];
					REG_V_TOTAL: ctrl.v_total <= req.wdata[TIMING_W-1:0];
					default: ; // Frame count and holes
				endcase
			end else if (req.bready) begin
				bvalid_q <= 1'b0;
			end

			if (rd_fire)
				rvalid_q <= 1'b1;
			else if (req.rready)
				rvalid_q <= 1'b0;
		end
	end

	always_ff @(posedge hdmi_pixClk) begin
		if (rd_fire) begin
			case (rd_reg)
				REG_CTRL:      rdata_q <= DATA_W'(ctrl.enable);
				REG_H_TOTAL:   rdata_q <= DATA_W'(ctrl.h_total);
				REG_V_TOTAL:   rdata_q <= DATA_W'(ctrl.v_total);
				REG_FRAME_CNT: rdata_q <= frame_cnt; // Sampled live
				default:       rdata_q <= '0;
			endcase
		end
	end

endmodule

/* design/boot_ram.sv */
`timescale 1ns/1ns

module boot_ram (
	input  logic                hdmi_pixClk,
	input  logic                arst_n,
	input  axil_pkg::axil_req_t req,
	output axil_pkg::axil_rsp_t rsp
);
	import axil_pkg::*;
	import soc_map_pkg::*;

	logic [DATA_W-1:0] mem [BOOT_WORDS];
	logic [DATA_W-1:0] rdata_q;
	logic bvalid_q;
	logic rvalid_q;

	logic busy;
	logic wr_fire;
	logic rd_fire;
	logic [BOOT_ADDR_BITS-3:0] wr_idx;
	logic [BOOT_ADDR_BITS-3:0] rd_idx;

	assign busy = bvalid_q || rvalid_q;
	assign wr_fire = req.awvalid && req.wvalid && !busy;
	assign rd_fire = req.arvalid && !busy && !(req.awvalid && req.wvalid);

	// Word index inside the window
	assign wr_idx = req.awaddr[BOOT_ADDR_BITS-1:2];
	assign rd_idx = req.araddr[BOOT_ADDR_BITS-1:2];

	always_comb begin
		rsp.awready = wr_fire;
		rsp.wready = wr_fire;
		rsp.bvalid = bvalid_q;
		rsp.bresp = RESP_OKAY;
		rsp.arready = rd_fire;
		rsp.rvalid = rvalid_q;
		rsp.rdata = rdata_q;
		rsp.rresp = RESP_OKAY;
	end

	always_ff @(posedge hdmi_pixClk or negedge arst_n) begin
		if (!arst_n) begin
			bvalid_q <= 1'b0;
			rvalid_q <= 1'b0;
		end else begin
			if (wr_fire)
				bvalid_q <= 1'b1;
			else if (req.bready)
				bvalid_q <= 1'b0;

			if (rd_fire)
				rvalid_q <= 1'b1;
			else if (req.rready)
				rvalid_q <= 1'b0;
		end
	end

	always_ff @(posedge hdmi_pixClk) begin
		if (wr_fire) begin
			for (int b = 0; b < STRB_W; b++) begin
				if (req.wstrb[b])
					mem[wr_idx][8*b +: 8] <= req.wdata[8*b +: 8];
			end
		end
		if (rd_fire)
			rdata_q <= mem[rd_idx]; // Held until rready
	end

endmodule

/* design/axil_decoder.sv */
`timescale 1ns/1ns

module axil_decoder (
	input  logic                hdmi_pixClk,
	input  logic                arst_n,
	input  axil_pkg::axil_req_t host_req,
	output axil_pkg::axil_rsp_t host_rsp,
	output axil_pkg::axil_req_t boot_req,
	input  axil_pkg::axil_rsp_t boot_rsp,
	output axil_pkg::axil_req_t gfx_req,
	input  axil_pkg::axil_rsp_t gfx_rsp
);
	import axil_pkg::*;
	import soc_map_pkg::*;

	typedef enum logic [1:0] {
		DEC_IDLE,
		DEC_FWD,
		DEC_WAIT,
		DEC_RESP
	} dec_state_e;

	dec_state_e state;
	logic is_wr;
	decode_sel_e sel;

	logic [ADDR_W-1:0] addr_q;
	logic [DATA_W-1:0] wdata_q;
	logic [STRB_W-1:0] wstrb_q;
	logic [DATA_W-1:0] rsp_data;
	axil_resp_e rsp_code;

	logic wr_start;
	logic rd_start;
	axil_rsp_t slv_rsp;
	logic slv_ack;
	logic slv_done;

	function automatic decode_sel_e decode(input logic [ADDR_W-1:0] a);
		if (a[ADDR_W-1:BOOT_ADDR_BITS] == BOOT_BASE[ADDR_W-1:BOOT_ADDR_BITS])
			return SEL_BOOT;
		if (a[ADDR_W-1:GFX_ADDR_BITS] == GFX_BASE[ADDR_W-1:GFX_ADDR_BITS])
			return SEL_GFX;
		return SEL_NONE;
	endfunction

	// Request as one slave sees it, valids only when that slave is the target
	function automatic axil_req_t route(input logic hit);
		axil_req_t r;
		r = '0;
		r.awaddr = addr_q;
		r.araddr = addr_q;
		r.wdata = wdata_q;
		r.wstrb = wstrb_q;
		r.awvalid = hit && state == DEC_FWD && is_wr;
		r.wvalid = hit && state == DEC_FWD && is_wr;
		r.arvalid = hit && state == DEC_FWD && !is_wr;
		r.bready = hit && state == DEC_WAIT && is_wr;
		r.rready = hit && state == DEC_WAIT && !is_wr;
		return r;
	endfunction

	// Write wins over a read arriving in the same cycle
	assign wr_start = state == DEC_IDLE && host_req.awvalid && host_req.wvalid;
	assign rd_start = state == DEC_IDLE && host_req.arvalid && !wr_start;

	assign slv_rsp = (sel == SEL_GFX) ? gfx_rsp : boot_rsp;
	assign slv_ack = is_wr ? (slv_rsp.awready && slv_rsp.wready) : slv_rsp.arready;
	assign slv_done = is_wr ? slv_rsp.bvalid : slv_rsp.rvalid;

	always_comb begin
		boot_req = route(sel == SEL_BOOT);
		gfx_req = route(sel == SEL_GFX);
	end

	always_comb begin
		host_rsp.awready = wr_start;
		host_rsp.wready = wr_start; // Raised with awready
		host_rsp.arready = rd_start;
		host_rsp.bvalid = state == DEC_RESP && is_wr;
		host_rsp.bresp = rsp_code;
		host_rsp.rvalid = state == DEC_RESP && !is_wr;
		host_rsp.rdata = rsp_data;
		host_rsp.rresp = rsp_code;
	end

	always_ff @(posedge hdmi_pixClk or negedge arst_n) begin
		if (!arst_n) begin
			state <= DEC_IDLE;
			is_wr <= 1'b0;
			sel <= SEL_NONE;
		end else begin
			case (state)
				DEC_IDLE: begin
					if (wr_start || rd_start) begin
						is_wr <= wr_start;
						sel <= decode(wr_start ? host_req.awaddr : host_req.araddr);
						state <= DEC_FWD;
					end
				end
				DEC_FWD: begin
					if (sel == SEL_NONE)
						state <= DEC_RESP; // Answered here, no slave involved
					else if (slv_ack)
						state <= DEC_WAIT;
				end
				DEC_WAIT: begin
					if (slv_done)
						state <= DEC_RESP;
				end
				DEC_RESP: begin
					if (is_wr ? host_req.bready : host_req.rready)
						state <= DEC_IDLE;
				end
				default: state <= DEC_IDLE;
			endcase
		end
	end

	always_ff @(posedge hdmi_pixClk) begin
		if (wr_start || rd_start) begin
			addr_q <= wr_start ? host_req.awaddr : host_req.araddr;
			wdata_q <= host_req.wdata;
			wstrb_q <= host_req.wstrb;
		end
		if (state == DEC_FWD && sel == SEL_NONE) begin
			rsp_data <= '0;
			rsp_code <= RESP_DECERR;
		end else if (state == DEC_WAIT && slv_done) begin
			rsp_data <= is_wr ? '0 : slv_rsp.rdata;
			rsp_code <= is_wr ? slv_rsp.bresp : slv_rsp.rresp;
		end
	end

endmodule

/* design/soc_map_pkg.sv */
package soc_map_pkg;

	// Graphics register window, 256 bytes
	localparam logic [31:0] GFX_BASE = 32'h0200_0000;
	localparam int GFX_ADDR_BITS = 8;

	// Boot memory window, 4 KiB
	localparam logic [31:0] BOOT_BASE = 32'h0201_0000;
	localparam int BOOT_ADDR_BITS = 12;
	localparam int BOOT_WORDS = 1024;

	localparam int TIMING_W = 12;

	// Word offsets inside the graphics window
	typedef enum logic [GFX_ADDR_BITS-3:0] {
		REG_CTRL      = 6'h00,
		REG_H_TOTAL   = 6'h01,
		REG_V_TOTAL   = 6'h02,
		REG_FRAME_CNT = 6'h03
	} gfx_reg_e;

	typedef struct packed {
		logic                enable;
		logic [TIMING_W-1:0] h_total;
		logic [TIMING_W-1:0] v_total;
	} gfx_ctrl_t;

	typedef enum logic [1:0] {
		SEL_BOOT,
		SEL_GFX,
		SEL_NONE
	} decode_sel_e;

endpackage

/* design/axil_pkg.sv */
package axil_pkg;

	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;
	localparam int STRB_W = DATA_W / 8;

	// Only the two codes this fabric can return
	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_DECERR = 2'b11
	} axil_resp_e;

	// Master to slave
	typedef struct packed {
		logic              awvalid;
		logic [ADDR_W-1:0] awaddr;
		logic              wvalid;
		logic [DATA_W-1:0] wdata;
		logic [STRB_W-1:0] wstrb;
		logic              bready;
		logic              arvalid;
		logic [ADDR_W-1:0] araddr;
		logic              rready;
	} axil_req_t;

	// Slave to master
	typedef struct packed {
		logic              awready;
		logic              wready;
		logic              bvalid;
		axil_resp_e        bresp;
		logic              arready;
		logic              rvalid;
		logic [DATA_W-1:0] rdata;
		axil_resp_e        rresp;
	} axil_rsp_t;

endpackage
